// File: hw/sample_buffer_defs.svh
`ifndef SAMPLE_BUFFER_DEFS_SVH
`define SAMPLE_BUFFER_DEFS_SVH

// Sample and address widths
`define SB_DATA_WIDTH      16
`define SB_ADDR_WIDTH      6

// Register port
`define SB_REG_WIDTH       32
`define SB_REG_ADDR_WIDTH  2
`define SB_REG_CTRLSTAT    0
`define SB_REG_START       1
`define SB_REG_END         2
`define SB_REG_STATUS      3

`define SB_SINK_CREDITS    4
`endif

// File: hw/sample_buffer_pkg.sv
`include "sample_buffer_defs.svh"

package sample_buffer_pkg;

    typedef logic [`SB_DATA_WIDTH-1:0]     sample_t;
    typedef logic [`SB_ADDR_WIDTH-1:0]     sample_addr_t;
    typedef logic [`SB_REG_WIDTH-1:0]      reg_data_t;
    typedef logic [`SB_REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Holds 0 to SB_SINK_CREDITS
    typedef logic [2:0]                    credit_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOOP,
        SEQ_ONE_SHOT
    } seq_state_t;

endpackage

// File: hw/sample_buffer_csr.sv
`timescale 1ns/1ps
`include "sample_buffer_defs.svh"

module sample_buffer_csr
    import sample_buffer_pkg::*;
(
    input  logic         stream_out,
    input  logic         reset,
    input  logic         reg_wr,
    input  reg_addr_t    reg_addr,
    input  reg_data_t    reg_wdata,
    output reg_data_t    reg_rdata,
    input  logic         trigger,
    input  logic         seq_stopped,
    input  sample_addr_t rd_addr,
    input  logic         running,
    output logic         ctrl_update,
    output logic         active,
    output logic         one_shot,
    output sample_addr_t start_offset,
    output sample_addr_t end_offset
);

    localparam int CTRL_ACTIVE_BIT   = 0;
    localparam int CTRL_ONE_SHOT_BIT = 1;
    localparam int STATUS_RUN_BIT    = 8;

    logic ctrl_wr;
    logic start_wr;
    logic end_wr;
    logic active_held;
    logic active_next;
    logic one_shot_next;
    logic update_next;

    assign ctrl_wr  = reg_wr && (reg_addr == reg_addr_t'(`SB_REG_CTRLSTAT));
    assign start_wr = reg_wr && (reg_addr == reg_addr_t'(`SB_REG_START));
    assign end_wr   = reg_wr && (reg_addr == reg_addr_t'(`SB_REG_END));

    // End of a one-shot run drops active without an update
    assign active_held = seq_stopped ? 1'b0 : active;

    always_comb begin
        active_next   = active_held;
        one_shot_next = one_shot;
        if (trigger) begin
            active_next = 1'b1;
        end
        // Register write wins over a trigger in the same cycle
        if (ctrl_wr) begin
            active_next   = reg_wdata[CTRL_ACTIVE_BIT];
            one_shot_next = reg_wdata[CTRL_ONE_SHOT_BIT];
        end
    end

    assign update_next = (active_next != active_held) || (one_shot_next != one_shot) || start_wr;

    always_ff @(posedge stream_out) begin
        if (reset) begin
            active       <= 1'b0;
            one_shot     <= 1'b0;
            start_offset <= '0;
            end_offset   <= '1;
            ctrl_update  <= 1'b0;
        end else begin
            active      <= active_next;
            one_shot    <= one_shot_next;
            ctrl_update <= update_next;
            if (start_wr) begin
                start_offset <= reg_wdata[`SB_ADDR_WIDTH-1:0];
            end
            if (end_wr) begin
                end_offset <= reg_wdata[`SB_ADDR_WIDTH-1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // Readback mux
    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            reg_addr_t'(`SB_REG_CTRLSTAT): begin
                reg_rdata[CTRL_ACTIVE_BIT]   = active;
                reg_rdata[CTRL_ONE_SHOT_BIT] = one_shot;
            end
            reg_addr_t'(`SB_REG_START): reg_rdata[`SB_ADDR_WIDTH-1:0] = start_offset;
            reg_addr_t'(`SB_REG_END):   reg_rdata[`SB_ADDR_WIDTH-1:0] = end_offset;
            default: begin
                reg_rdata[`SB_ADDR_WIDTH-1:0] = rd_addr;
                reg_rdata[STATUS_RUN_BIT]     = running;
            end
        endcase
    end

endmodule

// File: hw/sample_ram.sv
`timescale 1ns/1ps
`include "sample_buffer_defs.svh"

module sample_ram
    import sample_buffer_pkg::*;
(
    input  logic         stream_out,
    input  logic         mem_wr,
    input  sample_addr_t mem_waddr,
    input  sample_t      mem_wdata,
    input  logic         rd_en,
    input  sample_addr_t rd_addr,
    output sample_t      rd_data
);

    localparam int DEPTH = 1 << `SB_ADDR_WIDTH;

    sample_t mem [0:DEPTH-1];

    //////////////////////////////////////////////////
    // Host load port
    always_ff @(posedge stream_out) begin
        if (mem_wr) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    //////////////////////////////////////////////////
    // Playback read port

    // Output register gives one cycle of latency
    always_ff @(posedge stream_out) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: hw/playback_sequencer.sv
`timescale 1ns/1ps
`include "sample_buffer_defs.svh"

module playback_sequencer
    import sample_buffer_pkg::*;
(
    input  logic         stream_out,
    input  logic         reset,
    input  logic         ctrl_update,
    input  logic         active,
    input  logic         one_shot,
    input  sample_addr_t start_offset,
    input  sample_addr_t end_offset,
    input  logic         can_issue,
    output logic         rd_en,
    output sample_addr_t rd_addr,
    output logic         running,
    output logic         seq_stopped
);

    seq_state_t   state;
    sample_addr_t addr;
    logic         at_end;

    assign running = (state != SEQ_IDLE);
    assign rd_addr = addr;
    assign at_end  = (addr >= end_offset);

    // No issue while the new settings are being loaded
    assign rd_en = running && can_issue && !ctrl_update;

    // Last read of a one-shot run
    assign seq_stopped = rd_en && (state == SEQ_ONE_SHOT) && at_end;

    //////////////////////////////////////////////////
    // State and address
    always_ff @(posedge stream_out) begin
        if (reset) begin
            state <= SEQ_IDLE;
            addr  <= '0;
        end else if (ctrl_update) begin
            addr <= start_offset;
            if (!active) begin
                state <= SEQ_IDLE;
            end else if (one_shot) begin
                state <= SEQ_ONE_SHOT;
            end else begin
                state <= SEQ_LOOP;
            end
        end else if (rd_en) begin
            if (!at_end) begin
                addr <= addr + 1'b1;
            end else if (state == SEQ_LOOP) begin
                addr <= start_offset;
            end else begin
                // Address stays at end for the status read
                state <= SEQ_IDLE;
            end
        end
    end

endmodule

// File: hw/credit_stream_out.sv
`timescale 1ns/1ps
`include "sample_buffer_defs.svh"

module credit_stream_out
    import sample_buffer_pkg::*;
(
    input  logic    stream_out,
    input  logic    reset,
    input  logic    rd_en,
    input  sample_t rd_data,
    input  logic    credit_return,
    output logic    can_issue,
    output logic    sample_valid,
    output sample_t sample_data
);

    credit_t credits;

    //////////////////////////////////////////////////
    // Sink credits

    // One credit per issued read, one back per consumed sample
    always_ff @(posedge stream_out) begin
        if (reset) begin
            credits <= credit_t'(`SB_SINK_CREDITS);
        end else begin
            case ({rd_en, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign can_issue = (credits != '0);

    //////////////////////////////////////////////////
    // Output alignment

    // RAM read latency is one cycle
    always_ff @(posedge stream_out) begin
        if (reset) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= rd_en;
        end
    end

    // Quiet data bus between samples
    assign sample_data = sample_valid ? rd_data : '0;

endmodule

// File: hw/sample_buffer_player.sv
`timescale 1ns/1ps
`include "sample_buffer_defs.svh"

module sample_buffer_player
    import sample_buffer_pkg::*;
(
    input  logic         stream_out,
    input  logic         reset,

    // Register port
    input  logic         reg_wr,
    input  reg_addr_t    reg_addr,
    input  reg_data_t    reg_wdata,
    output reg_data_t    reg_rdata,

    // Sample load port
    input  logic         mem_wr,
    input  sample_addr_t mem_waddr,
    input  sample_t      mem_wdata,

    input  logic         trigger,

    // Sink
    output logic         sample_valid,
    output sample_t      sample_data,
    input  logic         credit_return
);

    logic         ctrl_update;
    logic         active;
    logic         one_shot;
    sample_addr_t start_offset;
    sample_addr_t end_offset;
    logic         seq_stopped;
    logic         running;
    logic         can_issue;
    logic         rd_en;
    sample_addr_t rd_addr;
    sample_t      rd_data;

    sample_buffer_csr csr (
        .stream_out   (stream_out),
        .reset        (reset),
        .reg_wr       (reg_wr),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .trigger      (trigger),
        .seq_stopped  (seq_stopped),
        .rd_addr      (rd_addr),
        .running      (running),
        .ctrl_update  (ctrl_update),
        .active       (active),
        .one_shot     (one_shot),
        .start_offset (start_offset),
        .end_offset   (end_offset)
    );

    sample_ram ram (
        .stream_out (stream_out),
        .mem_wr     (mem_wr),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    playback_sequencer seq (
        .stream_out   (stream_out),
        .reset        (reset),
        .ctrl_update  (ctrl_update),
        .active       (active),
        .one_shot     (one_shot),
        .start_offset (start_offset),
        .end_offset   (end_offset),
        .can_issue    (can_issue),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .running      (running),
        .seq_stopped  (seq_stopped)
    );

    credit_stream_out out (
        .stream_out    (stream_out),
        .reset         (reset),
        .rd_en         (rd_en),
        .rd_data       (rd_data),
        .credit_return (credit_return),
        .can_issue     (can_issue),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data)
    );

endmodule

// File: tests/sample_buffer_sva.sv
`timescale 1ns/1ps
`include "sample_buffer_defs.svh"

module sample_buffer_sva
    import sample_buffer_pkg::*;
(
    input logic    stream_out,
    input logic    reset,
    input logic    rd_en,
    input logic    can_issue,
    input logic    sample_valid,
    input credit_t credits
);

    // Counter starts full and only refills from returned credits
    credit_bound: assert property (
        @(posedge stream_out) disable iff (reset)
        credits <= credit_t'(`SB_SINK_CREDITS)
    ) else $error("credit counter above initial count: %0d", credits);

    issue_needs_credit: assert property (
        @(posedge stream_out) disable iff (reset)
        rd_en |-> can_issue
    ) else $error("read issued without a credit");

    //////////////////////////////////////////////////
    // Output alignment
    valid_follows_issue: assert property (
        @(posedge stream_out) disable iff (reset)
        rd_en |=> sample_valid
    ) else $error("sample_valid missing one cycle after rd_en");

endmodule

bind credit_stream_out sample_buffer_sva credit_checks (
    .stream_out   (stream_out),
    .reset        (reset),
    .rd_en        (rd_en),
    .can_issue    (can_issue),
    .sample_valid (sample_valid),
    .credits      (credits)
);

// File: tests/sample_buffer_tb.sv
`timescale 1ns/1ps
`include "sample_buffer_defs.svh"

module sample_buffer_tb
    import sample_buffer_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int DEPTH        = 1 << `SB_ADDR_WIDTH;
    localparam int RUN_TIMEOUT  = 200;
    localparam int QUIET_CYCLES = 20;
    localparam int TEST_BUDGET  = 400;
    localparam int NUM_TESTS    = 6;
    localparam int WATCHDOG_NS  = (NUM_TESTS * TEST_BUDGET + 5) * CLK_PERIOD;

    logic         stream_out = 1'b0;
    logic         reset;
    logic         reg_wr;
    reg_addr_t    reg_addr;
    reg_data_t    reg_wdata;
    reg_data_t    reg_rdata;
    logic         mem_wr;
    sample_addr_t mem_waddr;
    sample_t      mem_wdata;
    logic         trigger;
    logic         sample_valid;
    sample_t      sample_data;
    logic         credit_return = 1'b0;

    sample_t      ref_mem [0:DEPTH-1];
    sample_t      got_data [$];
    int           return_due [$];
    int           cycle;
    int           credit_delay;
    logic         credit_hold;
    logic [15:0]  lfsr;
    int           error_count;
    int           tests_run;
    int           tests_failed;

    sample_buffer_player UUT (
        .stream_out    (stream_out),
        .reset         (reset),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .mem_wr        (mem_wr),
        .mem_waddr     (mem_waddr),
        .mem_wdata     (mem_wdata),
        .trigger       (trigger),
        .sample_valid  (sample_valid),
        .sample_data   (sample_data),
        .credit_return (credit_return)
    );

    always #(CLK_PERIOD / 2) stream_out = ~stream_out;

    //////////////////////////////////////////////////
    // Sink model

    // Sample at mid-cycle where outputs are settled
    always @(negedge stream_out) begin
        if (!reset && sample_valid) begin
            got_data.push_back(sample_data);
            return_due.push_back(cycle + credit_delay);
        end
    end

    // At most one credit back per cycle
    always @(posedge stream_out) begin
        #1;
        cycle = cycle + 1;
        credit_return = 1'b0;
        if (!credit_hold && return_due.size() > 0 && return_due[0] <= cycle) begin
            credit_return = 1'b1;
            void'(return_due.pop_front());
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic sample_t ref_word(input int a);
        return ref_mem[sample_addr_t'(a)];
    endfunction

    task automatic step();
        @(posedge stream_out);
        #1;
    endtask

    task automatic settle(input int n);
        repeat (n) step();
    endtask

    task automatic report_mismatch(input string what, input int got, input int want);
        $display("ERROR %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, want);
        error_count++;
    endtask

    task automatic write_reg(input int a, input logic [31:0] d);
        reg_wr    = 1'b1;
        reg_addr  = reg_addr_t'(a);
        reg_wdata = d;
        step();
        reg_wr    = 1'b0;
    endtask

    task automatic read_reg(input int a, output reg_data_t d);
        reg_addr = reg_addr_t'(a);
        @(negedge stream_out);
        d = reg_rdata;
        step();
    endtask

    task automatic load_memory();
        sample_t word;
        for (int a = 0; a < DEPTH; a++) begin
            word = sample_t'(rand_bits(`SB_DATA_WIDTH));
            ref_mem[sample_addr_t'(a)] = word;
            mem_wr    = 1'b1;
            mem_waddr = sample_addr_t'(a);
            mem_wdata = word;
            step();
        end
        mem_wr = 1'b0;
    endtask

    task automatic wait_samples(input string name, input int total);
        int waited;
        waited = 0;
        while (got_data.size() < total && waited < RUN_TIMEOUT) begin
            step();
            waited++;
        end
        if (got_data.size() < total) begin
            $display("%s: timed out after %0d cycles with %0d of %0d samples received",
                     name, RUN_TIMEOUT, got_data.size(), total);
            error_count++;
        end
    endtask

    task automatic stop_playback();
        int waited;
        write_reg(`SB_REG_CTRLSTAT, 0);
        waited = 0;
        while ((return_due.size() > 0 || sample_valid) && waited < RUN_TIMEOUT) begin
            step();
            waited++;
        end
        if (return_due.size() > 0) begin
            $display("Sink still owed %0d credits after playback stopped", return_due.size());
            error_count++;
        end
        step();
    endtask

    task automatic check_sequence(input string name, input int base, input int count,
                                  input int start, input int span);
        for (int i = 0; i < count; i++) begin
            if (got_data[base + i] != ref_word(start + i % span)) begin
                report_mismatch($sformatf("%s sample %0d", name, i),
                                int'(got_data[base + i]), int'(ref_word(start + i % span)));
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs);
        tests_run++;
        if (error_count == errs) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, error_count - errs);
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    task automatic test_reset();
        int errs;
        reg_data_t rd;
        errs = error_count;
        for (int i = 0; i < 10; i++) begin
            @(negedge stream_out);
            if (sample_valid) begin
                report_mismatch("sample_valid after reset", 1, 0);
            end
        end
        step();
        read_reg(`SB_REG_CTRLSTAT, rd);
        if (rd != 0) begin
            report_mismatch("CTRLSTAT after reset", int'(rd), 0);
        end
        read_reg(`SB_REG_START, rd);
        if (rd != 0) begin
            report_mismatch("START after reset", int'(rd), 0);
        end
        read_reg(`SB_REG_END, rd);
        if (rd != reg_data_t'(DEPTH - 1)) begin
            report_mismatch("END after reset", int'(rd), DEPTH - 1);
        end
        finish_test("reset_defaults", errs);
    endtask

    task automatic test_loop();
        int errs;
        int base;
        errs = error_count;
        load_memory();
        write_reg(`SB_REG_START, 2);
        write_reg(`SB_REG_END, 5);
        credit_delay = 1;
        base = got_data.size();
        write_reg(`SB_REG_CTRLSTAT, 1);
        wait_samples("loop_playback", base + 20);
        stop_playback();
        check_sequence("loop", base, 20, 2, 4);
        finish_test("loop_playback", errs);
    endtask

    task automatic test_one_shot();
        int errs;
        int base;
        reg_data_t rd;
        errs = error_count;
        write_reg(`SB_REG_START, 10);
        write_reg(`SB_REG_END, 17);
        credit_delay = 2;
        base = got_data.size();
        write_reg(`SB_REG_CTRLSTAT, 3);
        wait_samples("one_shot", base + 8);
        settle(QUIET_CYCLES);
        if (got_data.size() != base + 8) begin
            report_mismatch("one-shot sample count", got_data.size() - base, 8);
        end
        check_sequence("one_shot", base, 8, 10, 8);
        read_reg(`SB_REG_CTRLSTAT, rd);
        if (rd[0] != 1'b0) begin
            report_mismatch("active after one-shot", int'(rd[0]), 0);
        end
        finish_test("one_shot", errs);
    endtask

    task automatic test_backpressure();
        int errs;
        int base;
        reg_data_t rd;
        errs = error_count;
        write_reg(`SB_REG_START, 20);
        write_reg(`SB_REG_END, 29);
        credit_delay = 1;
        credit_hold = 1'b1;
        base = got_data.size();
        write_reg(`SB_REG_CTRLSTAT, 1);
        settle(30);
        if (got_data.size() - base > `SB_SINK_CREDITS) begin
            report_mismatch("samples under held credits", got_data.size() - base,
                            `SB_SINK_CREDITS);
        end
        // Address waits at the first unissued word
        read_reg(`SB_REG_STATUS, rd);
        if (rd != reg_data_t'((1 << 8) | (20 + `SB_SINK_CREDITS))) begin
            report_mismatch("STATUS under held credits", int'(rd),
                            (1 << 8) | (20 + `SB_SINK_CREDITS));
        end
        credit_hold = 1'b0;
        wait_samples("backpressure", base + 16);
        stop_playback();
        check_sequence("backpressure", base, 16, 20, 10);
        finish_test("backpressure", errs);
    endtask

    task automatic test_trigger();
        int errs;
        int base;
        reg_data_t rd;
        errs = error_count;
        write_reg(`SB_REG_CTRLSTAT, 2);
        write_reg(`SB_REG_START, 40);
        write_reg(`SB_REG_END, 43);
        base = got_data.size();
        settle(3);
        if (got_data.size() != base) begin
            report_mismatch("samples before trigger", got_data.size() - base, 0);
        end
        trigger = 1'b1;
        step();
        trigger = 1'b0;
        wait_samples("trigger", base + 4);
        settle(QUIET_CYCLES);
        if (got_data.size() != base + 4) begin
            report_mismatch("triggered sample count", got_data.size() - base, 4);
        end
        check_sequence("trigger", base, 4, 40, 4);
        read_reg(`SB_REG_CTRLSTAT, rd);
        if (rd[0] != 1'b0) begin
            report_mismatch("active after triggered run", int'(rd[0]), 0);
        end
        finish_test("trigger", errs);
    endtask

    task automatic test_readback();
        int errs;
        logic [31:0] vs;
        logic [31:0] ve;
        reg_data_t rd;
        errs = error_count;
        repeat (8) begin
            vs = rand_bits(32);
            ve = rand_bits(32);
            write_reg(`SB_REG_START, vs);
            write_reg(`SB_REG_END, ve);
            read_reg(`SB_REG_START, rd);
            if (rd != (vs & (DEPTH - 1))) begin
                report_mismatch("START readback", int'(rd), int'(vs & (DEPTH - 1)));
            end
            read_reg(`SB_REG_END, rd);
            if (rd != (ve & (DEPTH - 1))) begin
                report_mismatch("END readback", int'(rd), int'(ve & (DEPTH - 1)));
            end
        end
        finish_test("register_readback", errs);
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    initial begin
        reset        = 1'b1;
        reg_wr       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        mem_wr       = 1'b0;
        mem_waddr    = '0;
        mem_wdata    = '0;
        trigger      = 1'b0;
        credit_delay = 1;
        credit_hold  = 1'b0;
        lfsr         = 16'd60;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (5) @(posedge stream_out);
        #1;
        reset = 1'b0;
        test_reset();
        test_loop();
        test_one_shot();
        test_backpressure();
        test_trigger();
        test_readback();
        $display("Summary: %0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

// File: sample_buffer.f
+incdir+hw
hw/sample_buffer_pkg.sv
hw/sample_buffer_csr.sv
hw/sample_ram.sv
hw/playback_sequencer.sv
hw/credit_stream_out.sv
hw/sample_buffer_player.sv
tests/sample_buffer_sva.sv
tests/sample_buffer_tb.sv

// File: Makefile
# Verilator lint and simulation for the sample playback buffer

LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f sample_buffer.f --top-module sample_buffer_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sample_buffer.f --top-module sample_buffer_tb -o sample_buffer_sim
	./obj_dir/sample_buffer_sim | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
